/* sources.f */
verilog/mspe_pkg.sv
verilog/mspe_csr.sv
verilog/mspe_decode.sv
verilog/mspe_execute.sv
verilog/mspe_result.sv
verilog/mspe.sv
bench/mspe_assert.sv
bench/mspe_tb.sv

/* bench/mspe_tb.sv */
`timescale 1ns/1ps

module mspe_tb;

    typedef struct packed {
        logic [31:0] data;
        logic        sop;
        logic        eop;
    } beat_t;

    logic                             clk;
    logic                             rst_n;
    logic [mspe_pkg::csr_addr_w-1:0]  csr_address;
    logic [mspe_pkg::data_w-1:0]      csr_writedata;
    logic                             csr_write;
    logic                             csr_read;
    logic [mspe_pkg::data_w-1:0]      csr_readdata;
    logic [mspe_pkg::data_w-1:0]      recv_fifo_q;
    logic [mspe_pkg::usedw_w-1:0]     recv_fifo_rdusedw;
    logic                             recv_fifo_rdreq;
    logic [mspe_pkg::data_w-1:0]      src_data;
    logic                             src_valid;
    logic                             src_sop;
    logic                             src_eop;

    logic [31:0] fifo[$];
    logic [31:0] stream[$];
    int          pkt_size[$];
    beat_t       expected[$];
    logic [31:0] model_key;
    logic [31:0] cur_key;
    logic [31:0] acc;
    logic [31:0] last_key;
    logic [3:0]  cur_op;
    logic        first_word;
    int          remaining;
    int          pkt_cnt;
    int          err_cnt;
    int          cycles;
    int          limit;

    mspe i_mspe (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
            $display("TESTS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic stop_on_error(input string why);
        $display("ERROR at %0t ns: %s", $time, why);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] transform(input logic [3:0] op, input logic [31:0] key,
                                              input logic [31:0] w);
        int r;
        r = key[4:0];
        case (op)
            mspe_pkg::op_add:  return w + key;
            mspe_pkg::op_xor:  return w ^ key;
            mspe_pkg::op_rotl: return (r == 0) ? w : ((w << r) | (w >> (32 - r)));
            default:           return w;
        endcase
    endfunction

    // Follows the packet framing of every word popped from the FIFO.
    task automatic model_pop(input logic [31:0] word);
        beat_t b;
        if (remaining == 0) begin
            remaining = word[7:0];
            if (remaining != 0) begin
                pkt_cnt++;
                cur_key    = model_key;
                acc        = model_key;
                first_word = 1'b1;
                cur_op     = (word[27:24] > 4) ? 4'd0 : word[27:24];
                err_cnt    = err_cnt + ((word[27:24] > 4) ? 1 : 0);
            end
        end else begin
            remaining--;
            acc = acc + word;
            b.data = (cur_op == mspe_pkg::op_sum) ? acc : transform(cur_op, cur_key, word);
            b.sop  = (cur_op == mspe_pkg::op_sum) ? 1'b1 : first_word;
            b.eop  = remaining == 0;
            if (cur_op != mspe_pkg::op_sum || remaining == 0) begin
                expected.push_back(b);
            end
            first_word = 1'b0;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
        recv_fifo_q       = (fifo.size() != 0) ? fifo[0] : '0;
        recv_fifo_rdusedw = fifo.size();
    endtask

    task automatic write_key(input logic [31:0] value);
        csr_address   = mspe_pkg::csr_key_addr;
        csr_writedata = value;
        csr_write     = 1'b1;
        tick();
        csr_write     = 1'b0;
        last_key      = value;
    endtask

    task automatic read_csr(input logic [2:0] addr, output logic [31:0] value);
        csr_address = addr;
        csr_read    = 1'b1;
        tick();
        csr_read    = 1'b0;
        value       = csr_readdata;
    endtask

    always @(negedge clk) begin
        beat_t want;
        if (rst_n) begin
            cycles++;
            if (cycles > limit) begin
                stop_on_error("timeout, the DUT stopped making progress");
            end else if (src_valid && expected.size() == 0) begin
                stop_on_error("output word seen with no word expected");
            end else begin
                if (src_valid) begin
                    want = expected.pop_front();
                    check_value("src_data", src_data, want.data);
                    check_value("src_sop", src_sop, want.sop);
                    check_value("src_eop", src_eop, want.eop);
                end
                if (recv_fifo_rdreq) begin
                    model_pop(fifo.pop_front());
                end
                // A header popped on this edge still takes the old key.
                if (csr_write && csr_address == mspe_pkg::csr_key_addr) begin
                    model_key = csr_writedata;
                end
            end
        end
    end

    initial begin
        int p;
        int w;
        int n;
        int widx;
        logic [31:0] hdr;
        logic [31:0] rd;
        void'($urandom(95199));
        clk = 1'b0;
        rst_n = 1'b0;
        csr_address = '0;
        csr_writedata = '0;
        csr_write = 1'b0;
        csr_read = 1'b0;
        recv_fifo_q = '0;
        recv_fifo_rdusedw = '0;
        model_key = '0;
        last_key = '0;
        remaining = 0;
        pkt_cnt = 0;
        err_cnt = 0;
        cycles = 0;
        for (p = 0; p < 40; p++) begin
            hdr = $urandom;
            hdr[27:24] = $urandom_range(0, 9);  // Codes above 4 are unknown.
            hdr[7:0] = $urandom_range(0, 12);
            stream.push_back(hdr);
            for (w = 0; w < hdr[7:0]; w++) begin
                stream.push_back($urandom);
            end
            pkt_size.push_back(hdr[7:0] + 1);
        end
        limit = 20 * stream.size() + 200;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        widx = 0;
        for (p = 0; p < pkt_size.size(); p++) begin
            if ($urandom_range(0, 3) == 0) begin
                write_key($urandom);
            end
            w = 0;
            while (w < pkt_size[p]) begin
                // Bursts let packets queue up behind key writes.
                for (n = $urandom_range(0, 3); n > 0 && w < pkt_size[p]; n--) begin
                    fifo.push_back(stream[widx]);
                    widx++;
                    w++;
                end
                tick();
            end
        end
        while (fifo.size() != 0) begin
            tick();
        end
        repeat (5) tick();  // Words in flight leave two cycles after their pop.
        read_csr(mspe_pkg::csr_pkt_addr, rd);
        check_value("packet count", rd, pkt_cnt);
        read_csr(mspe_pkg::csr_err_addr, rd);
        check_value("error count", rd, err_cnt);
        read_csr(mspe_pkg::csr_key_addr, rd);
        check_value("key", rd, last_key);
        if (expected.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_on_error("expected output words never appeared on the stream");
        end
    end

endmodule

/* bench/mspe_assert.sv */
`timescale 1ns/1ps

module mspe_assert (
    input logic clk,
    input logic rst_n,
    input logic recv_fifo_rdreq,
    input logic src_valid,
    input logic src_sop,
    input logic src_eop
);

    // An output word leaves two cycles after its pop.
    valid_after_pop: assert property (@(posedge clk) disable iff (!rst_n)
        src_valid |-> $past(recv_fifo_rdreq, 2))
        else $error("src_valid without a pop two cycles before");

    framing_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (src_sop || src_eop) |-> src_valid)
        else $error("sop or eop without valid");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !src_valid)
        else $error("src_valid high during reset");

endmodule

bind mspe mspe_assert i_assert (.*);

/* verilog/mspe.sv */
`timescale 1ns/1ps

module mspe (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic [mspe_pkg::csr_addr_w-1:0] csr_address,
    input  logic [mspe_pkg::data_w-1:0]     csr_writedata,
    input  logic                            csr_write,
    input  logic                            csr_read,
    output logic [mspe_pkg::data_w-1:0]     csr_readdata,

    input  logic [mspe_pkg::data_w-1:0]     recv_fifo_q,
    input  logic [mspe_pkg::usedw_w-1:0]    recv_fifo_rdusedw,
    output logic                            recv_fifo_rdreq,

    output logic [mspe_pkg::data_w-1:0]     src_data,
    output logic                            src_valid,
    output logic                            src_sop,
    output logic                            src_eop
);

    logic [mspe_pkg::data_w-1:0] key;
    mspe_pkg::op_t               op;
    mspe_pkg::res_t              res;
    logic                        op_valid;
    logic                        res_valid;
    logic                        pkt_start;
    logic                        bad_opcode;

    mspe_csr i_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (csr_address),
        .writedata  (csr_writedata),
        .write      (csr_write),
        .read       (csr_read),
        .pkt_start  (pkt_start),
        .bad_opcode (bad_opcode),
        .readdata   (csr_readdata),
        .key        (key)
    );

    mspe_decode i_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .fifo_q       (recv_fifo_q),
        .fifo_rdusedw (recv_fifo_rdusedw),
        .key          (key),
        .fifo_rdreq   (recv_fifo_rdreq),
        .op           (op),
        .op_valid     (op_valid),
        .pkt_start    (pkt_start),
        .bad_opcode   (bad_opcode)
    );

    mspe_execute i_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .op_valid  (op_valid),
        .res       (res),
        .res_valid (res_valid)
    );

    mspe_result i_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .src_data  (src_data),
        .src_valid (src_valid),
        .src_sop   (src_sop),
        .src_eop   (src_eop)
    );

endmodule

/* verilog/mspe_result.sv */
`timescale 1ns/1ps

module mspe_result (
    input  logic                        clk,
    input  logic                        rst_n,
    input  mspe_pkg::res_t              res,
    input  logic                        res_valid,
    output logic [mspe_pkg::data_w-1:0] src_data,
    output logic                        src_valid,
    output logic                        src_sop,
    output logic                        src_eop
);

    logic [mspe_pkg::data_w-1:0] acc;
    logic [mspe_pkg::data_w-1:0] acc_next;
    logic                        is_sum;

    assign is_sum = res.opcode == mspe_pkg::op_sum;

    // The first word of a sum packet starts from the key.
    assign acc_next = (res.first ? res.key : acc) + res.data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_valid <= 1'b0;
            src_sop   <= 1'b0;
            src_eop   <= 1'b0;
        end else begin
            src_valid <= res_valid && (!is_sum || res.last);
            src_sop   <= res_valid && (is_sum ? res.last : res.first);
            src_eop   <= res_valid && res.last;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            if (is_sum) begin
                acc <= acc_next;
            end
            src_data <= is_sum ? acc_next : res.data;  // Only seen on the last sum word.
        end
    end

endmodule

/* verilog/mspe_execute.sv */
`timescale 1ns/1ps

module mspe_execute (
    input  logic           clk,
    input  logic           rst_n,
    input  mspe_pkg::op_t  op,
    input  logic           op_valid,
    output mspe_pkg::res_t res,
    output logic           res_valid
);

    logic [mspe_pkg::data_w-1:0]   alu_out;
    logic [2*mspe_pkg::data_w-1:0] rot_wide;

    // Rotate by shifting a doubled word.
    assign rot_wide = {op.data, op.data} << op.key[mspe_pkg::rot_w-1:0];

    always_comb begin
        case (op.opcode)
            mspe_pkg::op_add:  alu_out = op.data + op.key;
            mspe_pkg::op_xor:  alu_out = op.data ^ op.key;
            mspe_pkg::op_rotl: alu_out = rot_wide[2*mspe_pkg::data_w-1 -: mspe_pkg::data_w];
            default:           alu_out = op.data;  // Pass, and raw word for sum.
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            res.opcode <= op.opcode;
            res.key    <= op.key;
            res.data   <= alu_out;
            res.first  <= op.first;
            res.last   <= op.last;
        end
    end

endmodule

/* verilog/mspe_decode.sv */
`timescale 1ns/1ps

module mspe_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [mspe_pkg::data_w-1:0]    fifo_q,
    input  logic [mspe_pkg::usedw_w-1:0]   fifo_rdusedw,
    input  logic [mspe_pkg::data_w-1:0]    key,
    output logic                           fifo_rdreq,
    output mspe_pkg::op_t                  op,
    output logic                           op_valid,
    output logic                           pkt_start,
    output logic                           bad_opcode
);

    mspe_pkg::decode_state_t     state;
    mspe_pkg::opcode_t           pkt_op;
    mspe_pkg::opcode_t           hdr_op;
    logic [mspe_pkg::data_w-1:0] pkt_key;
    logic [mspe_pkg::len_w-1:0]  remaining;
    logic [mspe_pkg::len_w-1:0]  hdr_len;
    logic [3:0]                  hdr_code;
    logic                        hdr_known;
    logic                        first_q;
    logic                        pop;

    assign pop        = fifo_rdusedw != '0;
    assign fifo_rdreq = pop;  // Headers and payload words alike.
    assign op_valid   = (state == mspe_pkg::st_payload) && pop;

    assign hdr_code = fifo_q[mspe_pkg::op_msb:mspe_pkg::op_lsb];
    assign hdr_len  = fifo_q[mspe_pkg::len_w-1:0];

    always_comb begin
        case (hdr_code)
            mspe_pkg::op_pass,
            mspe_pkg::op_add,
            mspe_pkg::op_xor,
            mspe_pkg::op_rotl,
            mspe_pkg::op_sum: hdr_known = 1'b1;
            default:          hdr_known = 1'b0;
        endcase
    end

    // Unknown codes run as pass.
    assign hdr_op = hdr_known ? mspe_pkg::opcode_t'(hdr_code) : mspe_pkg::op_pass;

    assign op.opcode = pkt_op;
    assign op.key    = pkt_key;
    assign op.data   = fifo_q;
    assign op.first  = first_q;
    assign op.last   = remaining == 1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= mspe_pkg::st_idle;
            remaining  <= '0;
            first_q    <= 1'b0;
            pkt_start  <= 1'b0;
            bad_opcode <= 1'b0;
        end else begin
            pkt_start  <= 1'b0;
            bad_opcode <= 1'b0;
            case (state)
                mspe_pkg::st_idle: begin
                    if (pop && hdr_len != '0) begin
                        state      <= mspe_pkg::st_payload;
                        remaining  <= hdr_len;
                        first_q    <= 1'b1;
                        pkt_start  <= 1'b1;
                        bad_opcode <= !hdr_known;
                    end
                end
                mspe_pkg::st_payload: begin
                    if (pop) begin
                        remaining <= remaining - 1'b1;
                        first_q   <= 1'b0;
                        if (remaining == 1) begin
                            state <= mspe_pkg::st_idle;
                        end
                    end
                end
                default: state <= mspe_pkg::st_idle;
            endcase
        end
    end

    // Packet opcode and key, taken when the header is popped.
    always_ff @(posedge clk) begin
        if (state == mspe_pkg::st_idle && pop) begin
            pkt_op  <= hdr_op;
            pkt_key <= key;
        end
    end

endmodule

/* verilog/mspe_csr.sv */
`timescale 1ns/1ps

module mspe_csr (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [mspe_pkg::csr_addr_w-1:0]   address,
    input  logic [mspe_pkg::data_w-1:0]       writedata,
    input  logic                              write,
    input  logic                              read,
    input  logic                              pkt_start,
    input  logic                              bad_opcode,
    output logic [mspe_pkg::data_w-1:0]       readdata,
    output logic [mspe_pkg::data_w-1:0]       key
);

    logic [mspe_pkg::data_w-1:0] pkt_count;
    logic [mspe_pkg::data_w-1:0] err_count;
    logic [mspe_pkg::data_w-1:0] read_mux;

    always_comb begin
        case (address)
            mspe_pkg::csr_key_addr: read_mux = key;
            mspe_pkg::csr_pkt_addr: read_mux = pkt_count;
            mspe_pkg::csr_err_addr: read_mux = err_count;
            default:                read_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key       <= '0;
            pkt_count <= '0;
            err_count <= '0;
            readdata  <= '0;
        end else begin
            // Only the key is writable.
            if (write && address == mspe_pkg::csr_key_addr) begin
                key <= writedata;
            end
            if (pkt_start) begin
                pkt_count <= pkt_count + 1'b1;
            end
            if (bad_opcode) begin
                err_count <= err_count + 1'b1;
            end
            if (read) begin
                readdata <= read_mux;  // Held until the next read.
            end
        end
    end

endmodule

/* verilog/mspe_pkg.sv */
package mspe_pkg;

    localparam int data_w     = 32;
    localparam int len_w      = 8;  // Header bits 7:0.
    localparam int usedw_w    = 11;
    localparam int csr_addr_w = 3;
    localparam int rot_w      = $clog2(data_w);

    // Opcode field of the header word.
    localparam int op_msb = 27;
    localparam int op_lsb = 24;

    localparam logic [csr_addr_w-1:0] csr_key_addr = 3'd0;
    localparam logic [csr_addr_w-1:0] csr_pkt_addr = 3'd1;
    localparam logic [csr_addr_w-1:0] csr_err_addr = 3'd2;

    typedef enum logic [3:0] {
        op_pass = 4'd0,
        op_add  = 4'd1,
        op_xor  = 4'd2,
        op_rotl = 4'd3,
        op_sum  = 4'd4
    } opcode_t;

    typedef enum logic {
        st_idle,
        st_payload
    } decode_state_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [data_w-1:0] key;
        logic [data_w-1:0] data;
        logic              first;
        logic              last;
    } op_t;

    typedef struct packed {
        opcode_t           opcode;
        logic [data_w-1:0] key;  // Packet key, needed by the sum reduction.
        logic [data_w-1:0] data;
        logic              first;
        logic              last;
    } res_t;

endpackage
